/* compile.f */
isa_pkg.sv
ctrl_pkg.sv
id_decode_stage.sv
id_operand_stage.sv
id_branch_stage.sv
id_top.sv
tb_id_top.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - isa_pkg.sv
  - ctrl_pkg.sv
  - id_decode_stage.sv
  - id_operand_stage.sv
  - id_branch_stage.sv
  - id_top.sv
  - target: test
    files:
      - tb_id_top.sv

/* tb_id_top.sv */
module tb_id_top;
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import ctrl_pkg::*;

    localparam funct_t alu_functs [16] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or,
        fn_xor, fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav};
    localparam opcode_t branch_ops [4] = '{op_beq, op_bne, op_blez, op_bgtz};
    localparam reg_addr_t regimm_codes [4] = '{rt_bltz, rt_bgez, rt_bltzal, rt_bgezal};
    localparam int num_slots = 600;

    logic         clk;
    logic         reset;
    logic         in_valid;
    word_t        instr;
    word_t        pc;
    forward_src_e forward_rs;
    forward_src_e forward_rt;
    word_t        reg_r_data_1;
    word_t        reg_r_data_2;
    bypass_t      bypass;
    reg_addr_t    reg_r_addr_1;
    reg_addr_t    reg_r_addr_2;
    logic         out_valid;
    id_out_t      dut_out;

    word_t        rf [32];
    logic [15:0]  lfsr_state;
    int           cycle_count = 0;
    id_out_t      exp_q [$];
    int           due_q [$];
    id_out_t      exp_rec;
    int           exp_due;

    id_top UUT (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .instr        (instr),
        .pc           (pc),
        .forward_rs   (forward_rs),
        .forward_rt   (forward_rt),
        .reg_r_data_1 (reg_r_data_1),
        .reg_r_data_2 (reg_r_data_2),
        .bypass       (bypass),
        .reg_r_addr_1 (reg_r_addr_1),
        .reg_r_addr_2 (reg_r_addr_2),
        .out_valid    (out_valid),
        .out          (dut_out)
    );

    // register file model answers in the same cycle
    assign reg_r_data_1 = rf[reg_r_addr_1];
    assign reg_r_data_2 = rf[reg_r_addr_2];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic forward_src_e pick_fwd();
        logic [2:0] v;
        v = take_bits(3);
        return (v > 3'd6) ? fwd_nop : forward_src_e'(v);
    endfunction

    function automatic bypass_t random_bypass();
        bypass_t b;
        int      i;
        b = '0;
        for (i = 0; i < 6; i++) begin
            b = {b[159:0], take_bits(32)};
        end
        return b;
    endfunction

    function automatic word_t operand_value(forward_src_e sel, reg_addr_t addr, bypass_t bp);
        case (sel)
            fwd_exc_alu:  return bp.exc_alu_res;
            fwd_exp_alu:  return bp.exp_alu_res;
            fwd_memc_alu: return bp.memc_alu_res;
            fwd_memc_mem: return bp.memc_r_data;
            fwd_memp_alu: return bp.memp_alu_res;
            fwd_memp_mem: return bp.memp_r_data;
            default:      return rf[addr];
        endcase
    endfunction

    task automatic make_stimulus(output word_t ins, output forward_src_e frs,
                                 output forward_src_e frt);
        logic [2:0] kind;
        logic [2:0] sel;
        logic [3:0] idx;
        reg_addr_t  rs_f;
        reg_addr_t  rt_f;
        word_t      raw;
        raw  = take_bits(32);
        kind = take_bits(3);
        sel  = take_bits(3);
        idx  = take_bits(4);
        rs_f = raw[25:21];
        rt_f = raw[20:16];
        frs  = pick_fwd();
        frt  = pick_fwd();
        case (kind)
            3'd0, 3'd1, 3'd7: ins = {op_special, raw[25:6], alu_functs[idx]};
            3'd2, 3'd3:       ins = {op_addi | opcode_t'(sel), raw[25:0]};
            3'd4: begin
                // same register and source half the time so beq can hold
                if (take_bits(1) == 1) begin
                    rt_f = rs_f;
                    frt  = frs;
                end
                if (sel < 3'd4) ins = {branch_ops[sel[1:0]], rs_f, rt_f, raw[15:0]};
                else ins = {op_regimm, rs_f, regimm_codes[sel[1:0]], raw[15:0]};
            end
            3'd5: begin
                case (sel[1:0])
                    2'd0:    ins = {op_j, raw[25:0]};
                    2'd1:    ins = {op_jal, raw[25:0]};
                    2'd2:    ins = {op_special, raw[25:6], fn_jr};
                    default: ins = {op_special, raw[25:6], fn_jalr};
                endcase
            end
            default: begin
                case (sel[1:0])
                    2'd2:    ins = {op_special, raw[25:6], 2'b11, raw[3:0]};
                    2'd3:    ins = {op_regimm, rs_f, 2'b01, raw[18:0]};
                    default: ins = {raw[31:26] | 6'h10, raw[25:0]};
                endcase
            end
        endcase
    endtask

    function automatic id_out_t expected_out(word_t ins, word_t pc_in, forward_src_e frs,
                                             forward_src_e frt, bypass_t bp);
        id_out_t e;
        opcode_t op;
        funct_t  fn;
        logic    neg;
        logic    zero;
        word_t   offset;
        e         = '0;
        op        = ins[31:26];
        fn        = ins[5:0];
        e.pc      = pc_in;
        e.rs      = ins[25:21];
        e.rt      = ins[20:16];
        e.sa      = ins[10:6];
        e.rs_data = operand_value(frs, e.rs, bp);
        e.rt_data = operand_value(frt, e.rt, bp);
        e.is_ri   = 1'b1;
        neg       = e.rs_data[31];
        zero      = e.rs_data == 32'd0;
        offset    = {{14{ins[15]}}, ins[15:0], 2'b00};
        if (op == op_special) begin
            e.w_reg_dst = ins[15:11];
            e.src_b_sel = src_b_rt;
            case (fn)
                fn_add, fn_addu: e.alu_sel = alu_add;
                fn_sub, fn_subu: e.alu_sel = alu_sub;
                fn_slt:          e.alu_sel = alu_slt;
                fn_sltu:         e.alu_sel = alu_sltu;
                fn_and:          e.alu_sel = alu_and;
                fn_or:           e.alu_sel = alu_or;
                fn_xor:          e.alu_sel = alu_xor;
                fn_nor:          e.alu_sel = alu_nor;
                fn_sll, fn_sllv: e.alu_sel = alu_sll;
                fn_srl, fn_srlv: e.alu_sel = alu_srl;
                fn_sra, fn_srav: e.alu_sel = alu_sra;
                default:         e.alu_sel = alu_nop;
            endcase
            // bit 2 of funct marks the variable shifts
            if (fn inside {fn_sll, fn_srl, fn_sra, fn_sllv, fn_srlv, fn_srav}) begin
                e.src_a_sel = src_a_rt;
                e.src_b_sel = fn[2] ? src_b_rs : src_b_sa;
            end
            e.link       = fn == fn_jalr;
            e.take_jmp   = fn == fn_jr || fn == fn_jalr;
            e.is_jr      = e.take_jmp;
            e.jmp_target = e.rs_data;
            e.w_reg_ena  = e.alu_sel != alu_nop || e.link;
            e.is_ri      = e.alu_sel == alu_nop && !e.take_jmp;
        end else if (op inside {[op_addi:op_lui]}) begin
            e.is_ri     = 1'b0;
            e.w_reg_ena = 1'b1;
            e.w_reg_dst = e.rt;
            e.src_b_sel = src_b_imme;
            e.ext_imme  = (op >= op_andi) ? {16'h0000, ins[15:0]} : {{16{ins[15]}}, ins[15:0]};
            case (op)
                op_slti:  e.alu_sel = alu_slt;
                op_sltiu: e.alu_sel = alu_sltu;
                op_andi:  e.alu_sel = alu_and;
                op_ori:   e.alu_sel = alu_or;
                op_xori:  e.alu_sel = alu_xor;
                op_lui:   e.alu_sel = alu_lui;
                default:  e.alu_sel = alu_add;
            endcase
        end else if (op == op_j || op == op_jal) begin
            e.is_ri      = 1'b0;
            e.is_j_imme  = 1'b1;
            e.take_jmp   = 1'b1;
            e.jmp_target = {pc_in[31:28], ins[25:0], 2'b00};
            e.link       = op == op_jal;
            e.w_reg_ena  = e.link;
            e.w_reg_dst  = link_reg;
        end else if (op inside {[op_beq:op_bgtz]}) begin
            e.is_ri      = 1'b0;
            e.jmp_target = pc_in + 32'd4 + offset;
            case (op)
                op_beq:  e.take_jmp = e.rs_data == e.rt_data;
                op_bne:  e.take_jmp = e.rs_data != e.rt_data;
                op_blez: e.take_jmp = neg || zero;
                default: e.take_jmp = !neg && !zero;
            endcase
        end else if (op == op_regimm && e.rt inside {rt_bltz, rt_bgez, rt_bltzal, rt_bgezal}) begin
            // rt bit 0 selects gez and bit 4 adds the link
            e.is_ri      = 1'b0;
            e.jmp_target = pc_in + 32'd4 + offset;
            e.take_jmp   = e.rt[0] ? !neg : neg;
            e.link       = e.rt[4];
            e.w_reg_ena  = e.rt[4];
            e.w_reg_dst  = link_reg;
        end
        return e;
    endfunction

    task automatic abort_run(string why);
        $display("ERROR: %s at time %0t", why, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("output value mismatch");
        end
    endtask

    task automatic compare_record(id_out_t e, int due);
        check_value("out_valid_cycle", cycle_count, due);
        check_value("pc", dut_out.pc, e.pc);
        check_value("rs", dut_out.rs, e.rs);
        check_value("rt", dut_out.rt, e.rt);
        check_value("is_ri", dut_out.is_ri, e.is_ri);
        check_value("rs_data", dut_out.rs_data, e.rs_data);
        check_value("rt_data", dut_out.rt_data, e.rt_data);
        check_value("take_jmp", dut_out.take_jmp, e.take_jmp);
        check_value("is_j_imme", dut_out.is_j_imme, e.is_j_imme);
        check_value("is_jr", dut_out.is_jr, e.is_jr);
        check_value("link", dut_out.link, e.link);
        check_value("w_reg_ena", dut_out.w_reg_ena, e.w_reg_ena);
        if (e.w_reg_ena) check_value("w_reg_dst", dut_out.w_reg_dst, e.w_reg_dst);
        if (e.take_jmp) check_value("jmp_target", dut_out.jmp_target, e.jmp_target);
        // plain alu instructions write back without a link
        if (e.w_reg_ena && !e.link) begin
            check_value("alu_sel", dut_out.alu_sel, e.alu_sel);
            check_value("src_a_sel", dut_out.src_a_sel, e.src_a_sel);
            check_value("src_b_sel", dut_out.src_b_sel, e.src_b_sel);
            if (e.src_b_sel == src_b_imme) check_value("ext_imme", dut_out.ext_imme, e.ext_imme);
            if (e.src_b_sel == src_b_sa) check_value("sa", dut_out.sa, e.sa);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run("out_valid high with no instruction in flight");
                end else begin
                    exp_rec = exp_q.pop_front();
                    exp_due = due_q.pop_front();
                    compare_record(exp_rec, exp_due);
                end
            end else if (out_valid !== 1'b0) begin
                abort_run("out_valid is unknown");
            end else if (due_q.size() != 0 && due_q[0] <= cycle_count) begin
                abort_run("no output three cycles after the instruction entered");
            end
        end
    end

    initial begin
        word_t        ins;
        word_t        pc_raw;
        forward_src_e frs;
        forward_src_e frt;
        bypass_t      bp_now;
        word_t        pend_instr;
        word_t        pend_pc;
        forward_src_e pend_frs;
        forward_src_e pend_frt;
        int           pend_due;
        logic         pend_valid;
        int           slot;
        int           waited;
        lfsr_state = 16'd12;
        reset      = 1'b1;
        in_valid   = 1'b0;
        instr      = '0;
        pc         = '0;
        forward_rs = fwd_nop;
        forward_rt = fwd_nop;
        bypass     = '0;
        pend_valid = 1'b0;
        rf[0] = '0;
        for (slot = 1; slot < 32; slot++) begin
            rf[slot] = take_bits(32);
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        // idle stretch lets the checker catch a stray out_valid
        repeat (6) @(posedge clk);
        for (slot = 0; slot <= num_slots; slot++) begin
            @(posedge clk);
            // bypass for the instruction driven one edge earlier
            bp_now = random_bypass();
            bypass <= bp_now;
            if (pend_valid) begin
                exp_q.push_back(expected_out(pend_instr, pend_pc, pend_frs, pend_frt, bp_now));
                due_q.push_back(pend_due);
            end
            pend_valid = 1'b0;
            if (slot == num_slots || take_bits(2) == 0) begin
                in_valid <= 1'b0;
            end else begin
                make_stimulus(ins, frs, frt);
                pc_raw     = take_bits(30);
                pend_instr = ins;
                pend_pc    = {pc_raw[29:0], 2'b00};
                pend_frs   = frs;
                pend_frt   = frt;
                pend_due   = cycle_count + 4;
                pend_valid = 1'b1;
                in_valid   <= 1'b1;
                instr      <= ins;
                pc         <= pend_pc;
                forward_rs <= frs;
                forward_rt <= frt;
            end
        end
        waited = 0;
        while (due_q.size() != 0 && waited < 12) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);
        if (due_q.size() != 0) begin
            abort_run("pipeline did not drain before the timeout");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* id_top.sv */
module id_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  isa_pkg::word_t         instr,
    input  isa_pkg::word_t         pc,
    input  ctrl_pkg::forward_src_e forward_rs,
    input  ctrl_pkg::forward_src_e forward_rt,
    input  isa_pkg::word_t         reg_r_data_1,
    input  isa_pkg::word_t         reg_r_data_2,
    input  ctrl_pkg::bypass_t      bypass,
    output isa_pkg::reg_addr_t     reg_r_addr_1,
    output isa_pkg::reg_addr_t     reg_r_addr_2,
    output logic                   out_valid,
    output ctrl_pkg::id_out_t      out
);
    import ctrl_pkg::*;

    logic     dec_valid;
    decoded_t dec;
    logic     opr_valid;
    operand_t opr;

    id_decode_stage u_decode (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .instr      (instr),
        .pc         (pc),
        .forward_rs (forward_rs),
        .forward_rt (forward_rt),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    id_operand_stage u_operand (
        .clk          (clk),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec          (dec),
        .reg_r_data_1 (reg_r_data_1),
        .reg_r_data_2 (reg_r_data_2),
        .bypass       (bypass),
        .reg_r_addr_1 (reg_r_addr_1),
        .reg_r_addr_2 (reg_r_addr_2),
        .opr_valid    (opr_valid),
        .opr          (opr)
    );

    id_branch_stage u_branch (
        .clk       (clk),
        .reset     (reset),
        .opr_valid (opr_valid),
        .opr       (opr),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

/* id_branch_stage.sv */
module id_branch_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               opr_valid,
    input  ctrl_pkg::operand_t opr,
    output logic               out_valid,
    output ctrl_pkg::id_out_t  out
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    logic  cond_ok;
    logic  take_jmp;
    word_t jmp_target;

    always_comb begin
        case (opr.branch_cond)
            br_eq:   cond_ok = opr.rs_data == opr.rt_data;
            br_ne:   cond_ok = opr.rs_data != opr.rt_data;
            br_gez:  cond_ok = $signed(opr.rs_data) >= 32'sd0;
            br_gtz:  cond_ok = $signed(opr.rs_data) > 32'sd0;
            br_lez:  cond_ok = $signed(opr.rs_data) <= 32'sd0;
            br_ltz:  cond_ok = $signed(opr.rs_data) < 32'sd0;
            default: cond_ok = 1'b0;
        endcase
    end

    assign take_jmp = opr.is_jr | opr.is_j_imme | cond_ok;

    always_comb begin
        if (opr.branch_cond != br_none) begin
            // ext_imme is already sign extended for branches
            jmp_target = opr.pc + 32'd4 + {opr.ext_imme[29:0], 2'b00};
        end else if (opr.is_j_imme) begin
            jmp_target = {opr.pc[31:28], opr.j_imme, 2'b00};
        end else if (opr.is_jr) begin
            jmp_target = opr.rs_data;
        end else begin
            jmp_target = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= opr_valid;
        end
    end

    always_ff @(posedge clk) begin
        out.pc         <= opr.pc;
        out.rs         <= opr.rs;
        out.rt         <= opr.rt;
        out.sa         <= opr.sa;
        out.ext_imme   <= opr.ext_imme;
        out.alu_sel    <= opr.alu_sel;
        out.src_a_sel  <= opr.src_a_sel;
        out.src_b_sel  <= opr.src_b_sel;
        out.is_j_imme  <= opr.is_j_imme;
        out.is_jr      <= opr.is_jr;
        out.link       <= opr.link;
        out.w_reg_ena  <= opr.w_reg_ena;
        out.w_reg_dst  <= opr.w_reg_dst;
        out.is_ri      <= opr.is_ri;
        out.rs_data    <= opr.rs_data;
        out.rt_data    <= opr.rt_data;
        out.take_jmp   <= take_jmp;
        out.jmp_target <= jmp_target;
    end

    // whole valid chain must come out of reset clean
    out_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(out_valid))
        else $error("out_valid unknown after reset");

endmodule

/* id_operand_stage.sv */
module id_operand_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                dec_valid,
    input  ctrl_pkg::decoded_t  dec,
    input  isa_pkg::word_t      reg_r_data_1,
    input  isa_pkg::word_t      reg_r_data_2,
    input  ctrl_pkg::bypass_t   bypass,
    output isa_pkg::reg_addr_t  reg_r_addr_1,
    output isa_pkg::reg_addr_t  reg_r_addr_2,
    output logic                opr_valid,
    output ctrl_pkg::operand_t  opr
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    word_t rs_data;
    word_t rt_data;

    function automatic word_t pick_operand(forward_src_e sel, word_t rf_data, bypass_t bp);
        case (sel)
            fwd_exc_alu:  return bp.exc_alu_res;
            fwd_exp_alu:  return bp.exp_alu_res;
            fwd_memc_alu: return bp.memc_alu_res;
            fwd_memc_mem: return bp.memc_r_data;
            fwd_memp_alu: return bp.memp_alu_res;
            fwd_memp_mem: return bp.memp_r_data;
            default:      return rf_data;
        endcase
    endfunction

    // register file answers within the cycle
    assign reg_r_addr_1 = dec.rs;
    assign reg_r_addr_2 = dec.rt;

    assign rs_data = pick_operand(dec.forward_rs, reg_r_data_1, bypass);
    assign rt_data = pick_operand(dec.forward_rt, reg_r_data_2, bypass);

    always_ff @(posedge clk) begin
        if (reset) begin
            opr_valid <= 1'b0;
        end else begin
            opr_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        opr.pc          <= dec.pc;
        opr.rs          <= dec.rs;
        opr.rt          <= dec.rt;
        opr.sa          <= dec.sa;
        opr.ext_imme    <= dec.ext_imme;
        opr.j_imme      <= dec.j_imme;
        opr.alu_sel     <= dec.alu_sel;
        opr.src_a_sel   <= dec.src_a_sel;
        opr.src_b_sel   <= dec.src_b_sel;
        opr.branch_cond <= dec.branch_cond;
        opr.is_j_imme   <= dec.is_j_imme;
        opr.is_jr       <= dec.is_jr;
        opr.link        <= dec.link;
        opr.w_reg_ena   <= dec.w_reg_ena;
        opr.w_reg_dst   <= dec.w_reg_dst;
        opr.is_ri       <= dec.is_ri;
        opr.rs_data     <= rs_data;
        opr.rt_data     <= rt_data;
    end

    // selects come from the top inputs one cycle earlier
    forward_sel_known: assert property (@(posedge clk) disable iff (reset)
        dec_valid |-> !$isunknown({dec.forward_rs, dec.forward_rt})
                      && dec.forward_rs <= fwd_memp_mem
                      && dec.forward_rt <= fwd_memp_mem)
        else $error("forwarding select outside the defined sources");

endmodule

/* id_decode_stage.sv */
module id_decode_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  isa_pkg::word_t         instr,
    input  isa_pkg::word_t         pc,
    input  ctrl_pkg::forward_src_e forward_rs,
    input  ctrl_pkg::forward_src_e forward_rt,
    output logic                   dec_valid,
    output ctrl_pkg::decoded_t     dec
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    sa;
    imm16_t    imm;
    jimm26_t   j_imme;
    logic      i_type;
    logic      zero_ext;
    decoded_t  dec_next;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign sa     = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];
    assign j_imme = instr[25:0];

    assign i_type = opcode inside {op_addi, op_addiu, op_slti, op_sltiu,
                                   op_andi, op_ori, op_xori, op_lui};
    // logical immediates and lui take the raw field, everything else sign extends
    assign zero_ext = opcode inside {op_andi, op_ori, op_xori, op_lui};

    always_comb begin
        dec_next             = '0;
        dec_next.pc          = pc;
        dec_next.rs          = rs;
        dec_next.rt          = rt;
        dec_next.sa          = sa;
        dec_next.j_imme      = j_imme;
        dec_next.forward_rs  = forward_rs;
        dec_next.forward_rt  = forward_rt;
        dec_next.alu_sel     = alu_nop;
        dec_next.src_a_sel   = src_a_rs;
        dec_next.src_b_sel   = src_b_nop;
        dec_next.branch_cond = br_none;
        dec_next.w_reg_dst   = rd;
        dec_next.ext_imme    = zero_ext ? {16'h0, imm} : {{16{imm[15]}}, imm};

        case (opcode)
            op_special: begin
                dec_next.w_reg_ena = 1'b1;
                dec_next.src_b_sel = src_b_rt;
                case (funct)
                    fn_add, fn_addu: dec_next.alu_sel = alu_add;
                    fn_sub, fn_subu: dec_next.alu_sel = alu_sub;
                    fn_slt:          dec_next.alu_sel = alu_slt;
                    fn_sltu:         dec_next.alu_sel = alu_sltu;
                    fn_and:          dec_next.alu_sel = alu_and;
                    fn_nor:          dec_next.alu_sel = alu_nor;
                    fn_or:           dec_next.alu_sel = alu_or;
                    fn_xor:          dec_next.alu_sel = alu_xor;
                    fn_sll, fn_sllv: dec_next.alu_sel = alu_sll;
                    fn_sra, fn_srav: dec_next.alu_sel = alu_sra;
                    fn_srl, fn_srlv: dec_next.alu_sel = alu_srl;
                    fn_jr: begin
                        dec_next.is_jr     = 1'b1;
                        dec_next.w_reg_ena = 1'b0;
                        dec_next.src_b_sel = src_b_nop;
                    end
                    fn_jalr: begin
                        // return address goes to rd
                        dec_next.is_jr     = 1'b1;
                        dec_next.link      = 1'b1;
                        dec_next.src_b_sel = src_b_nop;
                    end
                    default: begin
                        dec_next.is_ri     = 1'b1;
                        dec_next.w_reg_ena = 1'b0;
                        dec_next.src_b_sel = src_b_nop;
                    end
                endcase
                // shifts operate on rt, amount from sa or rs
                if (funct inside {fn_sll, fn_srl, fn_sra}) begin
                    dec_next.src_a_sel = src_a_rt;
                    dec_next.src_b_sel = src_b_sa;
                end else if (funct inside {fn_sllv, fn_srlv, fn_srav}) begin
                    dec_next.src_a_sel = src_a_rt;
                    dec_next.src_b_sel = src_b_rs;
                end
            end
            op_regimm: begin
                case (rt)
                    rt_bltz: dec_next.branch_cond = br_ltz;
                    rt_bgez: dec_next.branch_cond = br_gez;
                    rt_bltzal, rt_bgezal: begin
                        dec_next.branch_cond = rt[0] ? br_gez : br_ltz;
                        dec_next.link        = 1'b1;
                        dec_next.w_reg_ena   = 1'b1;
                        dec_next.w_reg_dst   = link_reg;
                    end
                    default: dec_next.is_ri = 1'b1;
                endcase
            end
            op_j:    dec_next.is_j_imme = 1'b1;
            op_jal: begin
                dec_next.is_j_imme = 1'b1;
                dec_next.link      = 1'b1;
                dec_next.w_reg_ena = 1'b1;
                dec_next.w_reg_dst = link_reg;
            end
            op_beq:            dec_next.branch_cond = br_eq;
            op_bne:            dec_next.branch_cond = br_ne;
            op_blez:           dec_next.branch_cond = br_lez;
            op_bgtz:           dec_next.branch_cond = br_gtz;
            op_addi, op_addiu: dec_next.alu_sel = alu_add;
            op_slti:           dec_next.alu_sel = alu_slt;
            op_sltiu:          dec_next.alu_sel = alu_sltu;
            op_andi:           dec_next.alu_sel = alu_and;
            op_ori:            dec_next.alu_sel = alu_or;
            op_xori:           dec_next.alu_sel = alu_xor;
            op_lui:            dec_next.alu_sel = alu_lui;
            default:           dec_next.is_ri = 1'b1;
        endcase

        if (i_type) begin
            dec_next.src_b_sel = src_b_imme;
            dec_next.w_reg_ena = 1'b1;
            dec_next.w_reg_dst = rt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec <= dec_next;
    end

    // the branch stage relies on at most one kind of control transfer
    jump_kind_onehot: assert property (@(posedge clk) disable iff (reset)
        dec_valid |-> $onehot0({dec.is_j_imme, dec.is_jr, dec.branch_cond != br_none}))
        else $error("decode record holds more than one jump kind");

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_sra,
        alu_srl,
        alu_lui,
        alu_nop
    } alu_sel_e;

    typedef enum logic {
        src_a_rs,
        src_a_rt
    } src_a_sel_e;

    typedef enum logic [2:0] {
        src_b_rt,
        src_b_imme,
        src_b_rs,
        src_b_sa,
        src_b_nop
    } src_b_sel_e;

    typedef enum logic [2:0] {
        br_none,
        br_eq,
        br_ne,
        br_gez,
        br_gtz,
        br_lez,
        br_ltz
    } branch_cond_e;

    // fwd_nop keeps the register file value
    typedef enum logic [2:0] {
        fwd_nop,
        fwd_exc_alu,
        fwd_exp_alu,
        fwd_memc_alu,
        fwd_memc_mem,
        fwd_memp_alu,
        fwd_memp_mem
    } forward_src_e;

    typedef struct packed {
        isa_pkg::word_t exc_alu_res;
        isa_pkg::word_t exp_alu_res;
        isa_pkg::word_t memc_alu_res;
        isa_pkg::word_t memc_r_data;
        isa_pkg::word_t memp_alu_res;
        isa_pkg::word_t memp_r_data;
    } bypass_t;

    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::shamt_t    sa;
        isa_pkg::word_t     ext_imme;
        isa_pkg::jimm26_t   j_imme;
        alu_sel_e           alu_sel;
        src_a_sel_e         src_a_sel;
        src_b_sel_e         src_b_sel;
        branch_cond_e       branch_cond;
        logic               is_j_imme;
        logic               is_jr;
        logic               link;
        logic               w_reg_ena;
        isa_pkg::reg_addr_t w_reg_dst;
        logic               is_ri;
        forward_src_e       forward_rs;
        forward_src_e       forward_rt;
    } decoded_t;

    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::shamt_t    sa;
        isa_pkg::word_t     ext_imme;
        isa_pkg::jimm26_t   j_imme;
        alu_sel_e           alu_sel;
        src_a_sel_e         src_a_sel;
        src_b_sel_e         src_b_sel;
        branch_cond_e       branch_cond;
        logic               is_j_imme;
        logic               is_jr;
        logic               link;
        logic               w_reg_ena;
        isa_pkg::reg_addr_t w_reg_dst;
        logic               is_ri;
        isa_pkg::word_t     rs_data;
        isa_pkg::word_t     rt_data;
    } operand_t;

    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rs;
        isa_pkg::reg_addr_t rt;
        isa_pkg::shamt_t    sa;
        isa_pkg::word_t     ext_imme;
        alu_sel_e           alu_sel;
        src_a_sel_e         src_a_sel;
        src_b_sel_e         src_b_sel;
        logic               is_j_imme;
        logic               is_jr;
        logic               link;
        logic               w_reg_ena;
        isa_pkg::reg_addr_t w_reg_dst;
        logic               is_ri;
        isa_pkg::word_t     rs_data;
        isa_pkg::word_t     rt_data;
        logic               take_jmp;
        isa_pkg::word_t     jmp_target;
    } id_out_t;

endpackage

/* isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [25:0] jimm26_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // primary opcodes
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_regimm  = 6'h01;
    localparam opcode_t op_j       = 6'h02;
    localparam opcode_t op_jal     = 6'h03;
    localparam opcode_t op_beq     = 6'h04;
    localparam opcode_t op_bne     = 6'h05;
    localparam opcode_t op_blez    = 6'h06;
    localparam opcode_t op_bgtz    = 6'h07;
    localparam opcode_t op_addi    = 6'h08;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_sltiu   = 6'h0b;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;

    // special funct field
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_sra  = 6'h03;
    localparam funct_t fn_sllv = 6'h04;
    localparam funct_t fn_srlv = 6'h06;
    localparam funct_t fn_srav = 6'h07;
    localparam funct_t fn_jr   = 6'h08;
    localparam funct_t fn_jalr = 6'h09;
    localparam funct_t fn_add  = 6'h20;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_sub  = 6'h22;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;

    // regimm codes live in the rt field
    localparam reg_addr_t rt_bltz   = 5'h00;
    localparam reg_addr_t rt_bgez   = 5'h01;
    localparam reg_addr_t rt_bltzal = 5'h10;
    localparam reg_addr_t rt_bgezal = 5'h11;

    localparam reg_addr_t link_reg = 5'd31;

endpackage
